/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing -Wno-fatal -f build.f --top-module tb_fp_adder -Mdir obj_dir
	./obj_dir/Vtb_fp_adder | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

/* build.f */
hdl/fp_pkg.sv
hdl/panel_pkg.sv
hdl/fp_stage_if.sv
hdl/keypad_scanner.sv
hdl/operand_entry.sv
hdl/fp_align.sv
hdl/fp_sum_normalize.sv
hdl/seg_display.sv
hdl/fp_adder_top.sv
test/keypad_model.sv
test/tb_fp_adder.sv

/* hdl/fp_adder_top.sv */
`timescale 1ns/1ps

module fp_adder_top import fp_pkg::*, panel_pkg::*; #(
	parameter int scan_div = 50000
) (
	input  logic        clk,
	input  logic        reset,
	input  logic [1:0]  mode,
	input  logic [3:0]  key_col_n,
	output logic [3:0]  key_row_n,
	output logic [6:0]  hex0,
	output logic [6:0]  hex1,
	output logic [6:0]  hex2,
	output logic [6:0]  hex3,
	output logic [15:0] sum,
	output logic        sum_valid,
	output logic        over,
	output logic        under
);
	logic      key_event;
	key_code_t key_code;
	mode_t     mode_q;
	fp_word_t  op_a;
	fp_word_t  op_b;
	fp_word_t  sum_word;
	logic      start;

	fp_stage_if stage_if ();

	assign sum = sum_word;

	// ----------------------------------------
	// keypad and operand entry
	// ----------------------------------------
	keypad_scanner #(.scan_div(scan_div)) keypad_scanner_i (
		.clk(clk), .reset(reset), .key_col_n(key_col_n), .key_row_n(key_row_n),
		.key_event(key_event), .key_code(key_code));

	operand_entry operand_entry_i (
		.clk(clk), .reset(reset), .mode(mode_t'(mode)), .key_event(key_event),
		.key_code(key_code), .mode_q(mode_q), .op_a(op_a), .op_b(op_b), .start(start));

	// ----------------------------------------
	// adder pipeline and display
	// ----------------------------------------
	fp_align fp_align_i (
		.clk(clk), .reset(reset), .start(start), .op_a(op_a), .op_b(op_b), .stage(stage_if));

	fp_sum_normalize fp_sum_normalize_i (
		.clk(clk), .reset(reset), .stage(stage_if), .sum(sum_word), .sum_valid(sum_valid),
		.over(over), .under(under));

	seg_display seg_display_i (
		.mode_q(mode_q), .op_a(op_a), .op_b(op_b), .sum(sum_word),
		.hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3));

endmodule

/* hdl/fp_align.sv */
`timescale 1ns/1ps

// stage 1 of the adder pipeline
module fp_align import fp_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       start,
	input  fp_word_t   op_a,
	input  fp_word_t   op_b,
	fp_stage_if.source stage
);
	sig_t                 sig_a;
	sig_t                 sig_b;
	sig_t                 aligned_a;
	sig_t                 aligned_b;
	logic [exp_width-1:0] exp_big;

	// hidden bit only for a nonzero word
	assign sig_a = {op_a != '0, op_a.fields.frac, 2'b00};
	assign sig_b = {op_b != '0, op_b.fields.frac, 2'b00};

	// truncating shift, 13 or more empties the significand
	always_comb begin
		if (op_a.fields.exp >= op_b.fields.exp) begin
			exp_big = op_a.fields.exp;
			aligned_a = sig_a;
			aligned_b = sig_b >> (op_a.fields.exp - op_b.fields.exp);
		end else begin
			exp_big = op_b.fields.exp;
			aligned_a = sig_a >> (op_b.fields.exp - op_a.fields.exp);
			aligned_b = sig_b;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			stage.valid <= 1'b0;
		else
			stage.valid <= start;
	end

	always_ff @(posedge clk) begin
		stage.sign_a <= op_a.fields.sign;
		stage.sign_b <= op_b.fields.sign;
		stage.exp <= exp_big;
		stage.acc_a <= op_a.fields.sign ? -acc_t'(aligned_a) : acc_t'(aligned_a);
		stage.acc_b <= op_b.fields.sign ? -acc_t'(aligned_b) : acc_t'(aligned_b);
	end

endmodule

/* hdl/fp_pkg.sv */
package fp_pkg;

	// ----------------------------------------
	// half precision format
	// ----------------------------------------
	localparam int exp_width = 5;
	localparam int frac_width = 10;
	localparam int sig_width = 13;  // hidden, fraction, two guard bits
	localparam int acc_width = 15;  // signed sum of two significands
	localparam int exp_max = 31;    // overflow exponent

	typedef struct packed {
		logic                  sign;
		logic [exp_width-1:0]  exp;
		logic [frac_width-1:0] frac;
	} fp_fields_t;

	// keypad side sees hex digits, the adder sees fields
	typedef union packed {
		logic [3:0][3:0] nibble;
		fp_fields_t      fields;
	} fp_word_t;

	typedef logic [sig_width-1:0] sig_t;
	typedef logic [acc_width-1:0] acc_t;

endpackage

/* hdl/fp_stage_if.sv */
`timescale 1ns/1ps

// aligned operands between align and sum stages
interface fp_stage_if import fp_pkg::*; ();

	logic                 valid;
	logic                 sign_a;
	logic                 sign_b;
	logic [exp_width-1:0] exp;    // larger exponent
	acc_t                 acc_a;
	acc_t                 acc_b;

	modport source (output valid, output sign_a, output sign_b, output exp,
		output acc_a, output acc_b);
	modport sink (input valid, input sign_a, input sign_b, input exp,
		input acc_a, input acc_b);

endinterface

/* hdl/fp_sum_normalize.sv */
`timescale 1ns/1ps

// stages 2 and 3 of the adder pipeline
module fp_sum_normalize import fp_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	fp_stage_if.sink stage,
	output fp_word_t sum,
	output logic     sum_valid,
	output logic     over,
	output logic     under
);
	acc_t                 sum_c;
	acc_t                 mag_c;
	logic                 s2_valid;
	logic                 s2_sign;
	acc_t                 s2_mag;
	logic [exp_width-1:0] s2_exp;
	acc_t                 carry_mag;
	acc_t                 norm_mag;
	logic [exp_width:0]   exp_inc;
	logic [3:0]           lz;
	fp_word_t             result;
	logic                 ovf;
	logic                 unf;

	assign sum_c = stage.acc_a + stage.acc_b;
	assign mag_c = sum_c[acc_width-1] ? -sum_c : sum_c;

	// ----------------------------------------
	// stage 3 normalize
	// ----------------------------------------
	assign carry_mag = s2_mag >> 1;
	assign exp_inc = {1'b0, s2_exp} + 1'b1;

	always_comb begin
		lz = 4'd0;
		for (int i = 0; i < sig_width; i++) begin
			if (s2_mag[i])
				lz = 4'(sig_width - 1 - i);  // distance to bit 12
		end
		norm_mag = s2_mag << lz;
		result = '0;
		ovf = 1'b0;
		unf = 1'b0;
		if (s2_mag[sig_width]) begin
			result.fields.sign = s2_sign;
			if (exp_inc >= exp_max) begin
				result.fields.exp = exp_width'(exp_max);  // infinity
				ovf = 1'b1;
			end else begin
				result.fields.exp = exp_inc[exp_width-1:0];
				result.fields.frac = carry_mag[frac_width+1:2];
			end
		end else if (s2_mag != '0) begin
			if ({1'b0, lz} > s2_exp) begin
				unf = 1'b1;  // too small, flush to zero
			end else begin
				result.fields.sign = s2_sign;
				result.fields.exp = s2_exp - {1'b0, lz};
				result.fields.frac = norm_mag[frac_width+1:2];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			s2_valid <= 1'b0;
			sum_valid <= 1'b0;
			over <= 1'b0;
			under <= 1'b0;
			sum <= '0;
		end else begin
			s2_valid <= stage.valid;
			sum_valid <= s2_valid;
			over <= s2_valid && ovf;
			under <= s2_valid && unf;
			if (s2_valid)
				sum <= result;  // held until the next add
		end
	end

	// stage 2, like signs keep their common sign
	always_ff @(posedge clk) begin
		s2_sign <= (stage.sign_a == stage.sign_b) ? stage.sign_a : sum_c[acc_width-1];
		s2_mag <= mag_c;
		s2_exp <= stage.exp;
	end

endmodule

/* hdl/keypad_scanner.sv */
`timescale 1ns/1ps

module keypad_scanner import panel_pkg::*; #(
	parameter int scan_div = 50000
) (
	input  logic       clk,
	input  logic       reset,
	input  logic [3:0] key_col_n,
	output logic [3:0] key_row_n,
	output logic       key_event,
	output key_code_t  key_code
);
	localparam int cnt_width = $clog2(scan_div + 1);

	logic [cnt_width-1:0] div_cnt;
	logic [1:0]           phase;    // 0 drive, 1 sample, 2 release
	logic [1:0]           row;
	logic [15:0]          pressed;  // last sample of every key
	logic                 phase_end;
	logic                 sample_end;
	logic                 hit;
	logic [1:0]           hit_col;

	assign phase_end = (div_cnt == cnt_width'(scan_div - 1));
	assign sample_end = phase_end && (phase == 2'd1);

	// new press in the current row, highest column wins
	always_comb begin
		hit = 1'b0;
		hit_col = 2'd0;
		for (int c = 0; c < 4; c++) begin
			if (!key_col_n[c] && !pressed[{row, 2'(c)}]) begin
				hit = 1'b1;
				hit_col = 2'(c);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt <= '0;
			phase <= 2'd0;
			row <= 2'd0;
			key_row_n <= 4'hf;
			key_event <= 1'b0;
			pressed <= '0;
		end else begin
			key_event <= sample_end && hit;
			key_row_n <= (phase == 2'd2) ? 4'hf : ~(4'b0001 << row);
			if (phase_end) begin
				div_cnt <= '0;
				phase <= (phase == 2'd2) ? 2'd0 : phase + 2'd1;
				if (phase == 2'd2)
					row <= row + 2'd1;  // next row after release
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
			if (sample_end)
				pressed[{row, 2'b00} +: 4] <= ~key_col_n;
		end
	end

	always_ff @(posedge clk) begin
		if (sample_end && hit)
			key_code <= {row, hit_col};
	end

endmodule

/* hdl/operand_entry.sv */
`timescale 1ns/1ps

module operand_entry import fp_pkg::*, panel_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  mode_t     mode,
	input  logic      key_event,
	input  key_code_t key_code,
	output mode_t     mode_q,
	output fp_word_t  op_a,
	output fp_word_t  op_b,
	output logic      start
);
	key_digit_t digit;
	logic       mode_change;
	logic       take_key;

	assign digit = key_digit[key_code];
	assign mode_change = (mode != mode_q);
	assign take_key = key_event && digit.valid;  // * and # dropped here

	always_ff @(posedge clk) begin
		if (reset) begin
			mode_q <= mode_clear;
			op_a <= '0;
			op_b <= '0;
			start <= 1'b0;
		end else begin
			mode_q <= mode;
			start <= mode_change && (mode == mode_sum);  // one add per entry
			case (mode)
				mode_clear: begin
					op_a <= '0;
					op_b <= '0;
				end
				mode_enter_a: begin
					if (mode_change)
						op_a <= '0;
					else if (take_key)
						op_a <= {op_a.nibble[2:0], digit.value};
				end
				mode_enter_b: begin
					if (mode_change)
						op_b <= '0;
					else if (take_key)
						op_b <= {op_b.nibble[2:0], digit.value};
				end
				default: begin
				end
			endcase
		end
	end

endmodule

/* hdl/panel_pkg.sv */
package panel_pkg;

	typedef enum logic [1:0] {
		mode_clear   = 2'b00,
		mode_enter_a = 2'b01,
		mode_sum     = 2'b10,
		mode_enter_b = 2'b11
	} mode_t;

	// ----------------------------------------
	// keypad
	// ----------------------------------------
	typedef logic [3:0] key_code_t;  // row * 4 + column

	typedef struct packed {
		logic       valid;
		logic [3:0] value;
	} key_digit_t;

	// 1 2 3 A / 4 5 6 B / 7 8 9 C / * 0 # D
	localparam key_digit_t key_digit [16] = '{
		'{1'b1, 4'h1}, '{1'b1, 4'h2}, '{1'b1, 4'h3}, '{1'b1, 4'ha},
		'{1'b1, 4'h4}, '{1'b1, 4'h5}, '{1'b1, 4'h6}, '{1'b1, 4'hb},
		'{1'b1, 4'h7}, '{1'b1, 4'h8}, '{1'b1, 4'h9}, '{1'b1, 4'hc},
		'{1'b0, 4'h0}, '{1'b1, 4'h0}, '{1'b0, 4'h0}, '{1'b1, 4'hd}
	};

	// ----------------------------------------
	// seven segment, active low, gfedcba
	// ----------------------------------------
	typedef logic [6:0] seg_t;

	localparam seg_t seg_blank = 7'b1111111;

	localparam seg_t hex_seg [16] = '{
		7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
		7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
		7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
		7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
	};

endpackage

/* hdl/seg_display.sv */
`timescale 1ns/1ps

module seg_display import fp_pkg::*, panel_pkg::*; (
	input  mode_t    mode_q,
	input  fp_word_t op_a,
	input  fp_word_t op_b,
	input  fp_word_t sum,
	output seg_t     hex0,
	output seg_t     hex1,
	output seg_t     hex2,
	output seg_t     hex3
);
	fp_word_t word;
	seg_t     digit [4];

	always_comb begin
		case (mode_q)
			mode_enter_a: word = op_a;
			mode_enter_b: word = op_b;
			mode_sum:     word = sum;
			default:      word = '0;
		endcase
		// blank panel while cleared
		for (int i = 0; i < 4; i++) begin
			digit[i] = (mode_q == mode_clear) ? seg_blank : hex_seg[word.nibble[i]];
		end
	end

	assign hex0 = digit[0];  // low nibble
	assign hex1 = digit[1];
	assign hex2 = digit[2];
	assign hex3 = digit[3];

endmodule

/* test/keypad_model.sv */
`timescale 1ns/1ps

// one key of a 4x4 switch matrix, columns pulled up
module keypad_model import panel_pkg::*; (
	input  logic [3:0] key_row_n,
	input  key_code_t  key,
	input  logic       press,
	output logic [3:0] key_col_n
);
	logic [15:0] closed;  // switch state by key index

	always_comb begin
		closed = '0;
		if (press)
			closed[key] = 1'b1;
	end

	// a closed switch ties its column to its row
	always_comb begin
		key_col_n = 4'hf;
		for (int r = 0; r < 4; r++) begin
			for (int c = 0; c < 4; c++) begin
				if (!key_row_n[r] && closed[r*4 + c])
					key_col_n[c] = 1'b0;
			end
		end
	end

endmodule

/* test/tb_fp_adder.sv */
`timescale 1ns/1ps

module tb_fp_adder import fp_pkg::*, panel_pkg::*; ();

	localparam int scan_div = 4;
	localparam int scan_cycles = 12 * scan_div;    // one full keypad scan
	localparam int key_cycles = 4 * scan_cycles;   // held 2 scans, released 2
	localparam int rand_pairs = 6;
	localparam int key_total = 2 * 8 + 8 * (rand_pairs + 3);
	localparam int timeout_limit = 2 * (key_total * key_cycles + (rand_pairs + 3) * 40 + 200);

	logic        clk;
	logic        reset;
	logic [1:0]  mode;
	logic [3:0]  key_col_n;
	logic [3:0]  key_row_n;
	logic [6:0]  hex0;
	logic [6:0]  hex1;
	logic [6:0]  hex2;
	logic [6:0]  hex3;
	logic [15:0] sum;
	logic        sum_valid;
	logic        over;
	logic        under;
	key_code_t   key;
	logic        press;

	int cycles = 0;
	int valid_count = 0;
	int adds = 0;
	int word_errors = 0;
	int seg_errors = 0;
	int flag_errors = 0;
	int row_errors = 0;
	int other_errors = 0;

	fp_adder_top #(.scan_div(scan_div)) fp_adder_top_i (
		.clk(clk), .reset(reset), .mode(mode), .key_col_n(key_col_n), .key_row_n(key_row_n),
		.hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3), .sum(sum),
		.sum_valid(sum_valid), .over(over), .under(under));

	keypad_model keypad_model_i (
		.key_row_n(key_row_n), .key(key), .press(press), .key_col_n(key_col_n));

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (sum_valid)
			valid_count <= valid_count + 1;
		if ((over || under) && !sum_valid) begin
			other_errors <= other_errors + 1;
			$display("flag pulse without sum_valid at %0t", $time);
		end
		if (cycles == timeout_limit) begin
			$display("run stopped by timeout after %0d cycles", cycles);
			$display("Something failed");
			$finish;
		end
	end

	// ----------------------------------------
	// compare tasks
	// ----------------------------------------
	task automatic check_word(input string name, input fp_word_t got, input fp_word_t expected);
		if (got !== expected) begin
			word_errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, expected);
		end
	endtask

	task automatic check_seg(input string name, input seg_t got, input seg_t expected);
		if (got !== expected) begin
			seg_errors++;
			$display("Error at %0t: %s is %b, expected %b", $time, name, got, expected);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			flag_errors++;
			$display("Error at %0t: %s is %b, expected %b", $time, name, got, expected);
		end
	endtask

	task automatic check_rows(input string name, input logic [3:0] got,
			input logic [3:0] expected);
		if (got !== expected) begin
			row_errors++;
			$display("Error at %0t: %s is %b, expected %b", $time, name, got, expected);
		end
	endtask

	task automatic check_display(input fp_word_t w, input logic blank);
		seg_t shown [4];
		shown = '{hex0, hex1, hex2, hex3};
		for (int i = 0; i < 4; i++)
			check_seg($sformatf("hex%0d", i), shown[i], blank ? seg_blank : hex_seg[w.nibble[i]]);
	endtask

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	task automatic model_add(input fp_word_t a, input fp_word_t b, output fp_word_t s,
			output logic ovf, output logic unf);
		int sig_a;
		int sig_b;
		int exp_s;
		int diff;
		int total;
		int mag;
		int shift;
		logic neg;
		sig_a = ((a != 0) ? 4096 : 0) + int'(a.fields.frac) * 4;  // hidden, frac, guard
		sig_b = ((b != 0) ? 4096 : 0) + int'(b.fields.frac) * 4;
		if (a.fields.exp >= b.fields.exp) begin
			exp_s = a.fields.exp;
			diff = exp_s - int'(b.fields.exp);
			sig_b = (diff >= 13) ? 0 : sig_b >> diff;
		end else begin
			exp_s = b.fields.exp;
			diff = exp_s - int'(a.fields.exp);
			sig_a = (diff >= 13) ? 0 : sig_a >> diff;
		end
		total = (a.fields.sign ? -sig_a : sig_a) + (b.fields.sign ? -sig_b : sig_b);
		neg = (total < 0);
		mag = neg ? -total : total;
		s = '0;
		ovf = 1'b0;
		unf = 1'b0;
		if (mag >= 8192) begin  // carry out of the hidden bit
			s.fields.sign = neg;
			if (exp_s + 1 >= exp_max) begin
				s.fields.exp = 5'(exp_max);
				ovf = 1'b1;
			end else begin
				s.fields.exp = 5'(exp_s + 1);
				s.fields.frac = 10'((mag >> 3) & 1023);
			end
		end else if (mag != 0) begin
			shift = 0;
			while (mag < 4096) begin
				mag = mag * 2;
				shift++;
			end
			if (shift > exp_s) begin
				unf = 1'b1;
			end else begin
				s.fields.sign = neg;
				s.fields.exp = 5'(exp_s - shift);
				s.fields.frac = 10'((mag >> 2) & 1023);
			end
		end
	endtask

	function automatic key_code_t key_for_digit(input logic [3:0] d);
		key_code_t k;
		k = '0;
		for (int i = 15; i >= 0; i--) begin
			if (key_digit[i].valid && key_digit[i].value == d)
				k = key_code_t'(i);
		end
		return k;
	endfunction

	// E and F have no key and become C and D
	function automatic fp_word_t keypad_word(input logic [15:0] w);
		fp_word_t k;
		k = w;
		for (int i = 0; i < 4; i++) begin
			if (k.nibble[i] > 4'hd)
				k.nibble[i] = k.nibble[i] - 4'h2;
		end
		return k;
	endfunction

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	task automatic set_mode(input mode_t m);
		@(negedge clk);
		mode = m;
		@(negedge clk);
	endtask

	task automatic type_key(input key_code_t k, inout fp_word_t model);
		key = k;
		press = 1'b1;
		repeat (2 * scan_cycles) @(negedge clk);
		press = 1'b0;
		repeat (2 * scan_cycles) @(negedge clk);
		if (key_digit[k].valid)
			model = {model.nibble[2:0], key_digit[k].value};
	endtask

	task automatic type_random(input mode_t m);
		fp_word_t model;
		key_code_t k;
		set_mode(m);
		model = '0;
		check_display(model, 1'b0);  // zeroed on entry
		for (int i = 0; i < 8; i++) begin
			k = (i == 2) ? key_code_t'(12) : (i == 5) ? key_code_t'(14) : 4'($urandom);
			type_key(k, model);
			check_display(model, 1'b0);
		end
	endtask

	task automatic enter_operand(input mode_t m, input fp_word_t w);
		fp_word_t model;
		set_mode(m);
		model = '0;
		check_display(model, 1'b0);
		for (int i = 3; i >= 0; i--)
			type_key(key_for_digit(w.nibble[i]), model);
		check_display(model, 1'b0);
	endtask

	task automatic run_add(input fp_word_t a, input fp_word_t b);
		fp_word_t exp_sum;
		logic exp_over;
		logic exp_under;
		int n;
		model_add(a, b, exp_sum, exp_over, exp_under);
		enter_operand(mode_enter_a, a);
		enter_operand(mode_enter_b, b);
		@(negedge clk);
		mode = mode_sum;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!sum_valid && n < 16);
		adds++;
		if (!sum_valid) begin
			other_errors++;
			$display("no sum_valid for %h + %h", a, b);
		end else if (n != 4) begin
			other_errors++;
			$display("sum_valid came %0d cycles after the mode change, expected 4", n);
		end
		check_word("sum", sum, exp_sum);
		check_flag("over", over, exp_over);
		check_flag("under", under, exp_under);
		check_display(exp_sum, 1'b0);
		@(negedge clk);
		check_flag("sum_valid", sum_valid, 1'b0);  // single pulse
		check_word("sum", sum, exp_sum);
	endtask

	initial begin
		fp_word_t a;
		fp_word_t b;
		logic [3:0] rows_seen;
		clk = 1'b0;
		reset = 1'b1;
		mode = mode_clear;
		key = '0;
		press = 1'b0;
		void'($urandom(35));
		repeat (4) @(negedge clk);
		reset = 1'b0;
		check_rows("key_row_n", key_row_n, 4'hf);  // all rows released in reset

		// idle in clear mode for one full scan
		rows_seen = '0;
		repeat (scan_cycles) begin
			@(negedge clk);
			check_display('0, 1'b1);
			check_flag("sum_valid", sum_valid, 1'b0);
			check_flag("over", over, 1'b0);
			check_flag("under", under, 1'b0);
			if ($countones(~key_row_n) > 1) begin
				row_errors++;
				$display("more than one keypad row driven low at %0t", $time);
			end
			rows_seen = rows_seen | ~key_row_n;
		end
		if (rows_seen != 4'hf) begin
			row_errors++;
			$display("not every keypad row was driven low during one scan");
		end

		type_random(mode_enter_a);
		type_random(mode_enter_b);

		for (int i = 0; i < rand_pairs; i++)
			run_add(keypad_word(16'($urandom)), keypad_word(16'($urandom)));

		a = keypad_word(16'($urandom) | 16'h8000);  // negative, so +b stays typeable
		b = a;
		b.fields.sign = 1'b0;  // exact cancel
		run_add(a, b);

		a = keypad_word({1'b0, 5'd30, 10'($urandom)});
		b = keypad_word({1'b0, 5'd30, 10'($urandom)});
		run_add(a, b);

		a = keypad_word({1'b0, 5'd2, 10'($urandom)});
		b = {1'b1, 5'd2, a.fields.frac ^ 10'd1};  // lsb apart, too small to normalize
		run_add(a, b);

		@(negedge clk);
		if (valid_count != adds) begin
			other_errors++;
			$display("%0d sum_valid pulses seen for %0d adds", valid_count, adds);
		end
		$display("errors: word %0d, segment %0d, flag %0d, row %0d, other %0d",
			word_errors, seg_errors, flag_errors, row_errors, other_errors);
		if (word_errors + seg_errors + flag_errors + row_errors + other_errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule
